/* sim.f */
mix_pkg.sv
opl_reg_pkg.sv
mix_ctrl_if.sv
channel_reg_file.sv
operator_out_mem.sv
channel_counter.sv
mix_sequencer.sv
mix_accumulator.sv
channel_mixer.sv
mix_checker.sv
tb_channel_mixer.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_channel_mixer -f sim.f

output=$(./obj_dir/Vtb_channel_mixer)
echo "$output"

if echo "$output" | grep -qxF '** PASS **'; then
    exit 0
else
    exit 1
fi

/* tb_channel_mixer.sv */
`timescale 1ns/1ns

module tb_channel_mixer import mix_pkg::*, opl_reg_pkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 5;
    localparam int NUM_ROWS       = 10;
    localparam int PASSES_PER_ROW = 2;   // second pass starts right after valid
    localparam int VALID_TIMEOUT  = 60;
    localparam int WATCHDOG_NS    =
        (NUM_ROWS * (27 + PASSES_PER_ROW * 40) + 100) * CLK_PERIOD;

    localparam logic [1:0] FILL_LFSR  = 2'd0;
    localparam logic [1:0] FILL_INDEX = 2'd1;  // distinct value per operator
    localparam logic [1:0] FILL_NEG   = 2'd2;  // index pattern negated

    localparam logic signed [OP_OUT_WIDTH-1:0] OP_FULL_POS = {1'b0, {(OP_OUT_WIDTH-1){1'b1}}};
    localparam logic signed [OP_OUT_WIDTH-1:0] OP_FULL_NEG = {1'b1, {(OP_OUT_WIDTH-1){1'b0}}};

    typedef struct packed {
        logic [0:NUM_CHANNELS-1][REG_DATA_WIDTH-1:0] ctrl;  // bit5 right, bit4 left, bit0 cnt
        logic [1:0]                                  fill;
        logic                                        full;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{ctrl: {8'h31, 8'h30, 8'h21, 8'h20, 8'h11, 8'h10, 8'h01, 8'h00, 8'h31},
          fill: FILL_LFSR, full: 1'b0},
        '{ctrl: {9{8'h31}}, fill: FILL_INDEX, full: 1'b0},
        '{ctrl: {9{8'h30}}, fill: FILL_INDEX, full: 1'b0},
        '{ctrl: {8'h30, 8'h31, 8'h30, 8'h31, 8'h30, 8'h31, 8'h30, 8'h31, 8'h30},
          fill: FILL_NEG, full: 1'b0},
        '{ctrl: {9{8'h11}}, fill: FILL_LFSR, full: 1'b0},   // left only
        '{ctrl: {9{8'h20}}, fill: FILL_LFSR, full: 1'b0},   // right only
        '{ctrl: {9{8'h01}}, fill: FILL_LFSR, full: 1'b0},   // routed nowhere
        '{ctrl: {9{8'h31}}, fill: FILL_INDEX, full: 1'b1},  // clamps high
        '{ctrl: {9{8'h31}}, fill: FILL_NEG, full: 1'b1},    // clamps low
        '{ctrl: {8'h11, 8'h21, 8'h31, 8'h01, 8'h31, 8'h20, 8'h10, 8'h31, 8'h30},
          fill: FILL_LFSR, full: 1'b1}
    };

    logic                           clk;
    logic                           rst_n;
    logic                           reg_wr;
    logic [REG_ADDR_WIDTH-1:0]      reg_addr;
    logic [REG_DATA_WIDTH-1:0]      reg_data;
    logic                           op_wr;
    logic [OP_NUM_WIDTH-1:0]        op_num;
    logic signed [OP_OUT_WIDTH-1:0] op_data;
    logic                           sample_clk_en;
    logic                           sample_valid;
    logic signed [SAMPLE_WIDTH-1:0] sample_l;
    logic signed [SAMPLE_WIDTH-1:0] sample_r;
    int                             value_errors;
    int                             timing_errors;
    int                             passes_checked;
    int                             tb_errors;
    logic [15:0]                    lfsr_state;

    channel_mixer dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .op_wr         (op_wr),
        .op_num        (op_num),
        .op_data       (op_data),
        .sample_clk_en (sample_clk_en),
        .sample_valid  (sample_valid),
        .sample_l      (sample_l),
        .sample_r      (sample_r)
    );

    mix_checker scoreboard (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_data       (reg_data),
        .op_wr          (op_wr),
        .op_num         (op_num),
        .op_data        (op_data),
        .sample_clk_en  (sample_clk_en),
        .sample_valid   (sample_valid),
        .sample_l       (sample_l),
        .sample_r       (sample_r),
        .value_errors   (value_errors),
        .timing_errors  (timing_errors),
        .passes_checked (passes_checked)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic take_random_bits(input int nbits, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[14:0], lfsr_state[0]};
        end
    endtask

    function automatic logic signed [OP_OUT_WIDTH-1:0] index_value(input int op);
        return OP_OUT_WIDTH'(op * 173 + 29);  // positive and unique per operator
    endfunction

    task automatic write_operator(input logic [OP_NUM_WIDTH-1:0] num,
                                  input logic signed [OP_OUT_WIDTH-1:0] data);
        op_wr   = 1'b1;
        op_num  = num;
        op_data = data;
        @(posedge clk);
        #DRIVE_DELAY;
        op_wr = 1'b0;
    endtask

    task automatic write_channel_ctrl(input int ch, input logic [REG_DATA_WIDTH-1:0] data);
        reg_wr   = 1'b1;
        reg_addr = CH_CTRL_BASE + REG_ADDR_WIDTH'(ch);
        reg_data = data;
        @(posedge clk);
        #DRIVE_DELAY;
        reg_wr = 1'b0;
    endtask

    task automatic fill_operators(input row_t row);
        logic [15:0]                    bits;
        logic signed [OP_OUT_WIDTH-1:0] value;
        for (int op = 0; op < NUM_OPERATORS; op++) begin
            case (row.fill)
                FILL_INDEX: value = index_value(op);
                FILL_NEG:   value = -index_value(op);
                default: begin
                    take_random_bits(OP_OUT_WIDTH, bits);
                    value = bits[OP_OUT_WIDTH-1:0];
                end
            endcase
            if (row.full) begin
                value = value[OP_OUT_WIDTH-1] ? OP_FULL_NEG : OP_FULL_POS;  // keep the sign
            end
            write_operator(OP_NUM_WIDTH'(op), value);
        end
    endtask

    task automatic run_pass(input int row_idx);
        bit seen;
        seen          = 1'b0;
        sample_clk_en = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        sample_clk_en = 1'b0;
        for (int i = 0; i < VALID_TIMEOUT && !seen; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            seen = sample_valid;
        end
        if (!seen) begin
            $display("timed out waiting for sample_valid in row %0d", row_idx);
            tb_errors++;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        reg_wr        = 1'b0;
        reg_addr      = '0;
        reg_data      = '0;
        op_wr         = 1'b0;
        op_num        = '0;
        op_data       = '0;
        sample_clk_en = 1'b0;
        tb_errors     = 0;
        lfsr_state    = 16'd3321;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        repeat (5) @(posedge clk);  // idle outputs watched before any pass
        #DRIVE_DELAY;
        for (int r = 0; r < NUM_ROWS; r++) begin
            fill_operators(ROWS[r]);
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                write_channel_ctrl(ch, ROWS[r].ctrl[ch]);
            end
            for (int p = 0; p < PASSES_PER_ROW; p++) begin
                run_pass(r);
            end
        end
        repeat (3) @(posedge clk);
        if (passes_checked != NUM_ROWS * PASSES_PER_ROW) begin
            $display("only %0d of %0d passes were checked", passes_checked,
                     NUM_ROWS * PASSES_PER_ROW);
            tb_errors++;
        end
        $display("errors: %0d value, %0d timing, %0d testbench",
                 value_errors, timing_errors, tb_errors);
        if (value_errors + timing_errors + tb_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("errors: %0d value, %0d timing, %0d testbench",
                 value_errors, timing_errors, tb_errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* mix_checker.sv */
`timescale 1ns/1ns

module mix_checker import mix_pkg::*, opl_reg_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           reg_wr,
    input  logic [REG_ADDR_WIDTH-1:0]      reg_addr,
    input  logic [REG_DATA_WIDTH-1:0]      reg_data,
    input  logic                           op_wr,
    input  logic [OP_NUM_WIDTH-1:0]        op_num,
    input  logic signed [OP_OUT_WIDTH-1:0] op_data,
    input  logic                           sample_clk_en,
    input  logic                           sample_valid,
    input  logic signed [SAMPLE_WIDTH-1:0] sample_l,
    input  logic signed [SAMPLE_WIDTH-1:0] sample_r,
    output int                             value_errors,
    output int                             timing_errors,
    output int                             passes_checked
);

    localparam int VALID_LATENCY = 29;  // cycles from enable edge to valid update
    localparam int SECOND_STRIDE = 3;   // second op sits three above the first
    localparam int SAT_MAX       = 32767;
    localparam int SAT_MIN       = -32768;

    logic [REG_DATA_WIDTH-1:0] ctrl_mirror [NUM_CHANNELS];
    int                        op_mirror [NUM_OPERATORS];
    int                        exp_l;
    int                        exp_r;
    int                        edges;      // sampling edges since the enable
    bit                        pending;
    bit                        seen_pass;

    function automatic int saturate(input int sum);
        if (sum > SAT_MAX) begin
            return SAT_MAX;
        end else if (sum < SAT_MIN) begin
            return SAT_MIN;
        end
        return sum;
    endfunction

    task automatic compute_expected(output int left, output int right);
        int first_idx;
        int value;
        left  = 0;
        right = 0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            first_idx = (ch / 3) * 6 + (ch % 3);  // three channels per six-op group
            if (ctrl_mirror[ch][CNT_BIT]) begin
                value = op_mirror[first_idx] + op_mirror[first_idx + SECOND_STRIDE];
            end else begin
                value = op_mirror[first_idx + SECOND_STRIDE];
            end
            if (ctrl_mirror[ch][LEFT_EN_BIT]) begin
                left += value;
            end
            if (ctrl_mirror[ch][RIGHT_EN_BIT]) begin
                right += value;
            end
        end
        left  = saturate(left);
        right = saturate(right);
    endtask

    task automatic compare_sample(input string name, input logic [SAMPLE_WIDTH-1:0] got,
                                  input logic [SAMPLE_WIDTH-1:0] want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%04h, expected 0x%04h", name, got, want);
            value_errors++;
        end
    endtask

    // inputs are driven mid-cycle, so the edge sees settled values
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                ctrl_mirror[ch] = '0;
            end
            pending        = 1'b0;
            seen_pass      = 1'b0;
            value_errors   = 0;
            timing_errors  = 0;
            passes_checked = 0;
        end else begin
            if (reg_wr && reg_addr >= CH_CTRL_BASE && reg_addr <= CH_CTRL_LAST) begin
                ctrl_mirror[CH_NUM_WIDTH'(reg_addr - CH_CTRL_BASE)] = reg_data;
            end
            if (op_wr) begin
                op_mirror[op_num] = int'(op_data);
            end
            if (pending) begin
                edges++;
                if (sample_valid) begin
                    if (edges != VALID_LATENCY + 1) begin  // seen one edge after update
                        $display("sample_valid came %0d cycles after sample_clk_en, not %0d",
                                 edges - 1, VALID_LATENCY);
                        timing_errors++;
                    end
                    compare_sample("sample_l", sample_l, exp_l[SAMPLE_WIDTH-1:0]);
                    compare_sample("sample_r", sample_r, exp_r[SAMPLE_WIDTH-1:0]);
                    pending = 1'b0;
                    passes_checked++;
                end else if (edges == VALID_LATENCY + 1) begin
                    $display("no sample_valid %0d cycles after sample_clk_en", VALID_LATENCY);
                    timing_errors++;
                    pending = 1'b0;
                end
            end else if (sample_valid) begin
                $display("sample_valid pulsed with no mixing pass running");
                timing_errors++;
            end
            if (!seen_pass && !pending) begin
                compare_sample("sample_l", sample_l, '0);  // reset value before any pass
                compare_sample("sample_r", sample_r, '0);
            end
            if (sample_clk_en) begin
                if (pending) begin
                    $display("sample_clk_en arrived while a pass was still running");
                    timing_errors++;
                end
                compute_expected(exp_l, exp_r);
                pending   = 1'b1;
                seen_pass = 1'b1;
                edges     = 0;
            end
        end
    end

endmodule

/* channel_mixer.sv */
`timescale 1ns/1ns

module channel_mixer import mix_pkg::*, opl_reg_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           reg_wr,
    input  logic [REG_ADDR_WIDTH-1:0]      reg_addr,
    input  logic [REG_DATA_WIDTH-1:0]      reg_data,
    input  logic                           op_wr,
    input  logic [OP_NUM_WIDTH-1:0]        op_num,
    input  logic signed [OP_OUT_WIDTH-1:0] op_data,
    input  logic                           sample_clk_en,
    output logic                           sample_valid,
    output logic signed [SAMPLE_WIDTH-1:0] sample_l,
    output logic signed [SAMPLE_WIDTH-1:0] sample_r
);

    logic [CH_NUM_WIDTH-1:0]        ch_num;
    logic [OP_NUM_WIDTH-1:0]        first_op;
    logic                           last_ch;
    logic                           clear;
    logic                           step;
    logic signed [OP_OUT_WIDTH-1:0] rd_data;
    logic                           cnt;
    logic                           left_en;
    logic                           right_en;

    mix_ctrl_if ctrl_if ();

    channel_reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .ch_num   (ch_num),
        .cnt      (cnt),
        .left_en  (left_en),
        .right_en (right_en)
    );

    operator_out_mem u_op_mem (
        .clk     (clk),
        .op_wr   (op_wr),
        .op_num  (op_num),
        .op_data (op_data),
        .ctrl    (ctrl_if.mem),
        .rd_data (rd_data)
    );

    channel_counter u_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .step     (step),
        .ch_num   (ch_num),
        .first_op (first_op),
        .last_ch  (last_ch)
    );

    mix_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .first_op      (first_op),
        .last_ch       (last_ch),
        .clear         (clear),
        .step          (step),
        .ctrl          (ctrl_if.seq)
    );

    mix_accumulator u_accumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl_if.acc),
        .rd_data      (rd_data),
        .cnt          (cnt),
        .left_en      (left_en),
        .right_en     (right_en),
        .sample_valid (sample_valid),
        .sample_l     (sample_l),
        .sample_r     (sample_r)
    );

endmodule

/* mix_accumulator.sv */
`timescale 1ns/1ns

module mix_accumulator import mix_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    mix_ctrl_if.acc                        ctrl,
    input  logic signed [OP_OUT_WIDTH-1:0] rd_data,
    input  logic                           cnt,
    input  logic                           left_en,
    input  logic                           right_en,
    output logic                           sample_valid,
    output logic signed [SAMPLE_WIDTH-1:0] sample_l,
    output logic signed [SAMPLE_WIDTH-1:0] sample_r
);

    logic signed [OP_OUT_WIDTH-1:0] second_q;  // captured second operator
    logic signed [OP_OUT_WIDTH:0]   ch_value;
    logic signed [ACC_WIDTH-1:0]    sum_l;
    logic signed [ACC_WIDTH-1:0]    sum_r;

    function automatic logic signed [SAMPLE_WIDTH-1:0] clamp(
        input logic signed [ACC_WIDTH-1:0] sum
    );
        if (sum > SAMPLE_MAX) begin
            return SAMPLE_MAX[SAMPLE_WIDTH-1:0];
        end else if (sum < SAMPLE_MIN) begin
            return SAMPLE_MIN[SAMPLE_WIDTH-1:0];
        end
        return sum[SAMPLE_WIDTH-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (ctrl.capture_second) begin
            second_q <= rd_data;
        end
    end

    // rd_data holds the first operator during accumulate
    always_comb begin
        if (cnt) begin
            ch_value = {rd_data[OP_OUT_WIDTH-1], rd_data}
                     + {second_q[OP_OUT_WIDTH-1], second_q};
        end else begin
            ch_value = {second_q[OP_OUT_WIDTH-1], second_q};  // fm passes the carrier only
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.acc_clear) begin
            sum_l <= '0;
            sum_r <= '0;
        end else if (ctrl.accumulate) begin
            if (left_en) begin
                sum_l <= sum_l + ACC_WIDTH'(ch_value);
            end
            if (right_en) begin
                sum_r <= sum_r + ACC_WIDTH'(ch_value);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
            sample_l     <= '0;
            sample_r     <= '0;
        end else begin
            sample_valid <= ctrl.latch;  // one-cycle pulse
            if (ctrl.latch) begin
                sample_l <= clamp(sum_l);
                sample_r <= clamp(sum_r);
            end
        end
    end

    in_range_passes: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.latch && sum_l >= SAMPLE_MIN && sum_l <= SAMPLE_MAX
            && sum_r >= SAMPLE_MIN && sum_r <= SAMPLE_MAX
        |=> sample_l == $past(sum_l) && sample_r == $past(sum_r))
        else $error("in-range sums altered by clamp");

endmodule

/* mix_sequencer.sv */
`timescale 1ns/1ns

module mix_sequencer import mix_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sample_clk_en,
    input  logic [OP_NUM_WIDTH-1:0] first_op,
    input  logic                    last_ch,
    output logic                    clear,
    output logic                    step,
    mix_ctrl_if.seq                 ctrl
);

    mix_state_t state;
    mix_state_t next_state;
    logic       start_pending;  // pass starts the cycle after the enable

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= IDLE;
            start_pending <= 1'b0;
        end else begin
            state         <= next_state;
            start_pending <= sample_clk_en && state == IDLE && !start_pending;
        end
    end

    always_comb begin
        next_state          = state;
        clear               = 1'b0;
        step                = 1'b0;
        ctrl.op_rd          = 1'b0;
        ctrl.op_addr        = first_op;
        ctrl.acc_clear      = 1'b0;
        ctrl.capture_second = 1'b0;
        ctrl.accumulate     = 1'b0;
        ctrl.latch          = 1'b0;
        case (state)
            IDLE: begin
                if (start_pending) begin
                    clear          = 1'b1;
                    ctrl.acc_clear = 1'b1;
                    next_state     = READ_SECOND;
                end
            end
            READ_SECOND: begin
                ctrl.op_rd   = 1'b1;
                ctrl.op_addr = first_op + SECOND_OP_OFFSET;
                next_state   = READ_FIRST;
            end
            READ_FIRST: begin
                ctrl.capture_second = 1'b1;  // second op is on rd_data now
                ctrl.op_rd          = 1'b1;
                next_state          = ACCUMULATE;
            end
            ACCUMULATE: begin
                ctrl.accumulate = 1'b1;
                if (last_ch) begin
                    next_state = DONE;
                end else begin
                    step       = 1'b1;
                    next_state = READ_SECOND;
                end
            end
            DONE: begin
                ctrl.latch = 1'b1;
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        sample_clk_en |-> state == IDLE && !start_pending)
        else $error("sample_clk_en during a mixing pass");

    // latch closes a pass on the last channel, three cycles per channel after the start
    latch_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.latch |-> state == DONE && last_ch && $past(start_pending, 3 * NUM_CHANNELS + 1))
        else $error("latch outside the end of a full mixing pass");

endmodule

/* channel_counter.sv */
`timescale 1ns/1ns

module channel_counter import mix_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    step,
    output logic [CH_NUM_WIDTH-1:0] ch_num,
    output logic [OP_NUM_WIDTH-1:0] first_op,
    output logic                    last_ch
);

    logic group_end;  // channel 2 or 5 ends an operator group

    assign group_end = ch_num == CH_NUM_WIDTH'(2) || ch_num == CH_NUM_WIDTH'(5);
    assign last_ch   = ch_num == CH_NUM_WIDTH'(NUM_CHANNELS - 1);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            ch_num   <= '0;
            first_op <= '0;
        end else if (step) begin
            ch_num <= ch_num + CH_NUM_WIDTH'(1);
            if (group_end) begin
                // hop over the block of second operators
                first_op <= first_op + SECOND_OP_OFFSET + OP_NUM_WIDTH'(1);
            end else begin
                first_op <= first_op + OP_NUM_WIDTH'(1);
            end
        end
    end

    ch_num_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        ch_num <= CH_NUM_WIDTH'(NUM_CHANNELS - 1))
        else $error("channel counter ran past the last channel");

endmodule

/* operator_out_mem.sv */
`timescale 1ns/1ns

module operator_out_mem import mix_pkg::*; (
    input  logic                           clk,
    input  logic                           op_wr,
    input  logic [OP_NUM_WIDTH-1:0]        op_num,
    input  logic signed [OP_OUT_WIDTH-1:0] op_data,
    mix_ctrl_if.mem                        ctrl,
    output logic signed [OP_OUT_WIDTH-1:0] rd_data
);

    logic signed [OP_OUT_WIDTH-1:0] mem [NUM_OPERATORS];

    always_ff @(posedge clk) begin
        if (op_wr) begin
            mem[op_num] <= op_data;
        end
    end

    // data shows up the cycle after op_rd
    always_ff @(posedge clk) begin
        if (ctrl.op_rd) begin
            rd_data <= mem[ctrl.op_addr];
        end
    end

    op_num_in_range: assert property (@(posedge clk)
        op_wr |-> op_num < NUM_OPERATORS)
        else $error("operator write index %0d out of range", op_num);

endmodule

/* channel_reg_file.sv */
`timescale 1ns/1ns

module channel_reg_file import mix_pkg::*, opl_reg_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      reg_wr,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [REG_DATA_WIDTH-1:0] reg_data,
    input  logic [CH_NUM_WIDTH-1:0]   ch_num,
    output logic                      cnt,
    output logic                      left_en,
    output logic                      right_en
);

    logic [2:0]                ch_ctrl [NUM_CHANNELS];  // {right, left, cnt}
    logic [REG_ADDR_WIDTH-1:0] wr_offset;
    logic [CH_NUM_WIDTH-1:0]   wr_idx;
    logic                      wr_hit;

    assign wr_offset = reg_addr - CH_CTRL_BASE;
    assign wr_idx    = wr_offset[CH_NUM_WIDTH-1:0];
    assign wr_hit    = reg_wr && reg_addr >= CH_CTRL_BASE && reg_addr <= CH_CTRL_LAST;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                ch_ctrl[i] <= 3'b000;
            end
        end else if (wr_hit) begin
            ch_ctrl[wr_idx] <= {reg_data[RIGHT_EN_BIT],
                                reg_data[LEFT_EN_BIT],
                                reg_data[CNT_BIT]};
        end
    end

    // read side is combinational at the sequencer's channel
    assign cnt      = ch_ctrl[ch_num][0];
    assign left_en  = ch_ctrl[ch_num][1];
    assign right_en = ch_ctrl[ch_num][2];

endmodule

/* mix_ctrl_if.sv */
`timescale 1ns/1ns

interface mix_ctrl_if import mix_pkg::*; ();

    logic                    op_rd;           // operator memory read strobe
    logic [OP_NUM_WIDTH-1:0] op_addr;         // operator to read
    logic                    acc_clear;       // zero both sums at pass start
    logic                    capture_second;  // hold second operator sample
    logic                    accumulate;      // add channel into sums
    logic                    latch;           // clamp and register outputs

    modport seq (
        output op_rd, op_addr, acc_clear, capture_second, accumulate, latch
    );

    modport mem (
        input op_rd, op_addr
    );

    modport acc (
        input acc_clear, capture_second, accumulate, latch
    );

endinterface

/* opl_reg_pkg.sv */
package opl_reg_pkg;

    localparam int REG_ADDR_WIDTH = 8;
    localparam int REG_DATA_WIDTH = 8;

    // channel control registers, one per channel
    localparam logic [REG_ADDR_WIDTH-1:0] CH_CTRL_BASE = 8'hC0;  // channel 0
    localparam logic [REG_ADDR_WIDTH-1:0] CH_CTRL_LAST = 8'hC8;  // channel 8

    // bit positions inside a channel control byte
    localparam int CNT_BIT      = 0;  // operator connection
    localparam int LEFT_EN_BIT  = 4;  // route to left output
    localparam int RIGHT_EN_BIT = 5;  // route to right output

endpackage

/* mix_pkg.sv */
package mix_pkg;

    // sample and accumulator widths
    localparam int OP_OUT_WIDTH = 13;
    localparam int SAMPLE_WIDTH = 16;
    localparam int ACC_WIDTH    = OP_OUT_WIDTH + 5;  // 9 channels of 2-op sums

    // bank geometry
    localparam int NUM_CHANNELS  = 9;
    localparam int NUM_OPERATORS = 18;
    localparam int OP_NUM_WIDTH  = 5;
    localparam int CH_NUM_WIDTH  = 4;

    // second operator sits 3 slots above the first
    localparam logic [OP_NUM_WIDTH-1:0] SECOND_OP_OFFSET = OP_NUM_WIDTH'(3);

    // clamp limits, held at accumulator width for comparison
    localparam logic signed [ACC_WIDTH-1:0] SAMPLE_MAX =
        ACC_WIDTH'((2 ** (SAMPLE_WIDTH - 1)) - 1);
    localparam logic signed [ACC_WIDTH-1:0] SAMPLE_MIN =
        ACC_WIDTH'(-(2 ** (SAMPLE_WIDTH - 1)));

    typedef enum logic [2:0] {
        IDLE,
        READ_SECOND,   // address second operator
        READ_FIRST,    // capture second, address first
        ACCUMULATE,    // add channel into left/right sums
        DONE           // clamp and latch outputs
    } mix_state_t;

endpackage
